//--- hw/key_counter_ctrl.sv
`timescale 1ns/100ps
`include "key_panel_config.svh"

module key_counter_ctrl
    import key_panel_pkg::*;
(
    input  logic       CLK,
    input  logic       RST_N,
    input  logic       empty,
    input  key_event_t rd_data,
    output logic       pop,
    output count_t     value,
    output logic       step_large,
    output rel_count_t release_count
);

    // Key roles
    localparam key_idx_t key_inc   = key_idx_t'(0);
    localparam key_idx_t key_dec   = key_idx_t'(1);
    localparam key_idx_t key_clear = key_idx_t'(2);
    localparam key_idx_t key_step  = key_idx_t'(3);

    logic   rd_valid;
    count_t step;

    assign step = step_large ? count_t'(`KP_STEP_LARGE) : count_t'(`KP_STEP_SMALL);

    //////////////////////////////
    // Pop pacing
    //////////////////////////////

    // At most one pop every two cycles, so empty is current when sampled
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            pop      <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            pop      <= !empty && !pop;
            rd_valid <= pop;
        end
    end

    //////////////////////////////
    // Event decode
    //////////////////////////////

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            value <= '0;
        end else if (rd_valid && rd_data.press) begin
            case (rd_data.key)
                key_inc:   value <= value + step;
                key_dec:   value <= value - step;
                key_clear: value <= '0;
                default:   value <= value;
            endcase
        end
    end

    // Key 3 press flips between small and large step
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            step_large <= 1'b0;
        end else if (rd_valid && rd_data.press && rd_data.key == key_step) begin
            step_large <= !step_large;
        end
    end

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            release_count <= '0;
        end else if (rd_valid && !rd_data.press) begin
            release_count <= release_count + 1'b1;
        end
    end

endmodule

//--- hw/key_debounce.sv
`timescale 1ns/100ps

module key_debounce #(
    parameter int DEBOUNCE_CYCLES = 20
) (
    input  logic CLK,
    input  logic RST_N,
    input  logic key,
    output logic level
);

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    typedef enum logic [1:0] {
        st_idle   = 2'b00,
        st_settle = 2'b01,
        st_stable = 2'b11
    } deb_state_t;

    deb_state_t       state;
    deb_state_t       next_state;
    logic [CNT_W-1:0] win_cnt;
    logic             win_done;
    logic             stable;

    assign win_done = (win_cnt == CNT_W'(DEBOUNCE_CYCLES));

    //////////////////////////////
    // State machine
    //////////////////////////////

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (key) begin
                    next_state = st_settle;
                end
            end
            // Sample the key once at the end of the window
            st_settle: begin
                if (win_done) begin
                    next_state = key ? st_stable : st_idle;
                end
            end
            st_stable: begin
                if (!key) begin
                    next_state = st_settle;
                end
            end
            default: next_state = st_idle;
        endcase
    end

    // Window counter runs only while staying in settle
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            win_cnt <= '0;
        end else if (state == st_settle && next_state == st_settle) begin
            win_cnt <= win_cnt + 1'b1;
        end else begin
            win_cnt <= '0;
        end
    end

    //////////////////////////////
    // Debounced level
    //////////////////////////////

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            stable <= 1'b0;
        end else if (state == st_settle && next_state == st_stable) begin
            stable <= 1'b1;
        end else if (state == st_settle && next_state == st_idle) begin
            stable <= 1'b0;
        end
    end

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            level <= 1'b0;
        end else begin
            level <= stable;
        end
    end

endmodule

//--- hw/key_event_encoder.sv
`timescale 1ns/100ps
`include "key_panel_config.svh"

module key_event_encoder
    import key_panel_pkg::*;
(
    input  logic                    CLK,
    input  logic                    RST_N,
    input  logic [`KP_NUM_KEYS-1:0] keys,
    output key_event_t              evt,
    output logic                    evt_strobe
);

    localparam int NK = `KP_NUM_KEYS;

    logic [NK-1:0] lvl;
    logic [NK-1:0] lvl_d;
    logic [NK-1:0] edges;
    logic [NK-1:0] pend;
    logic [NK-1:0] pend_dir;
    logic [NK-1:0] req;
    logic [NK-1:0] dir_next;
    logic [NK-1:0] pick_mask;
    logic          pick_hit;
    key_idx_t      pick_idx;

    //////////////////////////////
    // Debouncers
    //////////////////////////////

    for (genvar i = 0; i < NK; i++) begin : g_deb
        key_debounce #(
            .DEBOUNCE_CYCLES(`KP_DEBOUNCE_CYCLES)
        ) u_deb (
            .CLK  (CLK),
            .RST_N(RST_N),
            .key  (keys[i]),
            .level(lvl[i])
        );
    end

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            lvl_d <= '0;
        end else begin
            lvl_d <= lvl;
        end
    end

    assign edges = lvl ^ lvl_d;

    // New edges join the pending set, direction is the new level
    assign req      = pend | edges;
    assign dir_next = (edges & lvl) | (~edges & pend_dir);

    //////////////////////////////
    // Lowest index wins
    //////////////////////////////

    always_comb begin
        pick_mask = '0;
        pick_hit  = 1'b0;
        pick_idx  = '0;
        for (int i = NK - 1; i >= 0; i--) begin
            if (req[i]) begin
                pick_mask    = '0;
                pick_mask[i] = 1'b1;
                pick_hit     = 1'b1;
                pick_idx     = key_idx_t'(i);
            end
        end
    end

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            pend       <= '0;
            pend_dir   <= '0;
            evt_strobe <= 1'b0;
        end else begin
            pend       <= req & ~pick_mask;
            pend_dir   <= dir_next;
            evt_strobe <= pick_hit;
        end
    end

    // Event payload, only meaningful with the strobe
    always_ff @(posedge CLK) begin
        if (pick_hit) begin
            evt.key   <= pick_idx;
            evt.press <= dir_next[pick_idx];
        end
    end

endmodule

//--- hw/key_event_fifo.sv
`timescale 1ns/100ps

module key_event_fifo
    import key_panel_pkg::*;
#(
    parameter int DEPTH = 8
) (
    input  logic       CLK,
    input  logic       RST_N,
    input  logic       push,
    input  key_event_t wr_data,
    input  logic       pop,
    output key_event_t rd_data,
    output logic       empty,
    output logic       full,
    output logic       overflow
);

    localparam int PTR_W = $clog2(DEPTH);

    key_event_t       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign empty   = (count == '0);
    assign full    = (count == (PTR_W + 1)'(DEPTH));
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    //////////////////////////////
    // Storage
    //////////////////////////////

    always_ff @(posedge CLK) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Popped entry shows up one cycle after pop
    always_ff @(posedge CLK) begin
        if (do_pop) begin
            rd_data <= mem[rd_ptr];
        end
    end

    //////////////////////////////
    // Pointers and occupancy
    //////////////////////////////

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Dropped push, held until reset
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            overflow <= 1'b0;
        end else if (push && full) begin
            overflow <= 1'b1;
        end
    end

endmodule

//--- hw/key_panel_config.svh
`ifndef KEY_PANEL_CONFIG_SVH
`define KEY_PANEL_CONFIG_SVH

//////////////////////////////
// Front panel size
//////////////////////////////

// Number of mechanical keys on the panel
`define KP_NUM_KEYS 4

// Settle window in clock cycles, kept short for simulation
`define KP_DEBOUNCE_CYCLES 20

// Event FIFO entries, power of two
`define KP_FIFO_DEPTH 8

//////////////////////////////
// Counter steps
//////////////////////////////

`define KP_STEP_SMALL 1
`define KP_STEP_LARGE 10

`endif

//--- hw/key_panel_pkg.sv
`include "key_panel_config.svh"

package key_panel_pkg;

    //////////////////////////////
    // Key events
    //////////////////////////////

    // Index of one key on the panel
    typedef logic [$clog2(`KP_NUM_KEYS)-1:0] key_idx_t;

    // Press flag is 1 for a press, 0 for a release
    typedef struct packed {
        key_idx_t key;
        logic     press;
    } key_event_t;

    //////////////////////////////
    // Controller state
    //////////////////////////////

    // Counter value, wraps modulo 2^16
    typedef logic [15:0] count_t;

    // Release count, wraps
    typedef logic [7:0] rel_count_t;

    typedef struct packed {
        logic       step_large;
        logic       overflow;
        rel_count_t release_count;
    } panel_status_t;

endpackage

//--- hw/key_panel_top.sv
`timescale 1ns/100ps
`include "key_panel_config.svh"

module key_panel_top
    import key_panel_pkg::*;
(
    input  logic                    CLK,
    input  logic                    RST_N,
    input  logic [`KP_NUM_KEYS-1:0] keys,
    output count_t                  value,
    output panel_status_t           status
);

    key_event_t evt;
    logic       evt_strobe;
    key_event_t rd_data;
    logic       empty;
    logic       overflow;
    logic       pop;
    logic       step_large;
    rel_count_t release_count;

    //////////////////////////////
    // Producer, buffer, consumer
    //////////////////////////////

    key_event_encoder u_encoder (
        .CLK       (CLK),
        .RST_N     (RST_N),
        .keys      (keys),
        .evt       (evt),
        .evt_strobe(evt_strobe)
    );

    // Full drops the event inside the FIFO
    key_event_fifo #(
        .DEPTH(`KP_FIFO_DEPTH)
    ) u_fifo (
        .CLK     (CLK),
        .RST_N   (RST_N),
        .push    (evt_strobe),
        .wr_data (evt),
        .pop     (pop),
        .rd_data (rd_data),
        .empty   (empty),
        .full    (),
        .overflow(overflow)
    );

    key_counter_ctrl u_ctrl (
        .CLK          (CLK),
        .RST_N        (RST_N),
        .empty        (empty),
        .rd_data      (rd_data),
        .pop          (pop),
        .value        (value),
        .step_large   (step_large),
        .release_count(release_count)
    );

    assign status.step_large    = step_large;
    assign status.overflow      = overflow;
    assign status.release_count = release_count;

endmodule

//--- list.f
+incdir+hw
hw/key_panel_pkg.sv
hw/key_debounce.sv
hw/key_event_encoder.sv
hw/key_event_fifo.sv
hw/key_counter_ctrl.sv
hw/key_panel_top.sv
verification/tb_clock_gen.sv
verification/key_panel_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module key_panel_tb -f list.f -o key_panel_sim || exit 1
sim_out=$(./obj_dir/key_panel_sim)
echo "$sim_out"
echo "$sim_out" | grep -q "Simulation completed successfully" && exit 0 || exit 1

//--- verification/key_panel_tb.sv
`timescale 1ns/100ps
`include "key_panel_config.svh"

module key_panel_tb
    import key_panel_pkg::*;
();

    localparam int NK            = `KP_NUM_KEYS;
    localparam int QUIET_CYCLES  = 60;
    localparam int CHECK_TIMEOUT = 1000;
    localparam int RESET_TIMEOUT = 50;
    localparam int RANDOM_STEPS  = 200;

    // Expected controller state
    typedef struct packed {
        count_t     value;
        logic       step_large;
        rel_count_t releases;
    } model_t;

    logic          CLK;
    logic          RST_N;
    logic [NK-1:0] keys;
    count_t        value;
    panel_status_t status;

    model_t        model;
    logic [31:0]   lcg_state;
    logic          check_req;
    logic          check_done;
    int            quiet_cnt;
    int            wait_cnt;
    count_t        value_d;
    panel_status_t status_d;

    tb_clock_gen u_clk_gen (
        .CLK  (CLK),
        .RST_N(RST_N)
    );

    key_panel_top key_panel_top_inst (
        .CLK   (CLK),
        .RST_N (RST_N),
        .keys  (keys),
        .value (value),
        .status(status)
    );

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic model_t apply_event(input model_t m, input int key, input logic press);
        model_t r;
        count_t step;
        r    = m;
        step = m.step_large ? count_t'(`KP_STEP_LARGE) : count_t'(`KP_STEP_SMALL);
        if (!press) begin
            r.releases = m.releases + 8'd1;
        end else begin
            case (key)
                0:       r.value = m.value + step;
                1:       r.value = m.value - step;
                2:       r.value = '0;
                default: r.step_large = !m.step_large;
            endcase
        end
        return r;
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_equal(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("FAIL at %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
            $display("Simulation failed");
            $fatal(1, "Mismatch on %s", what);
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("Timed out while waiting for %s", what);
        $display("Simulation failed");
        $fatal(1, "Timeout");
    endtask

    //////////////////////////////
    // Checker
    //////////////////////////////

    // Compares once the DUT has been quiet for a while
    always @(posedge CLK) begin
        value_d  <= value;
        status_d <= status;
        if (!check_req) begin
            check_done <= 1'b0;
            quiet_cnt  <= 0;
            wait_cnt   <= 0;
        end else if (!check_done) begin
            wait_cnt <= wait_cnt + 1;
            if (wait_cnt >= CHECK_TIMEOUT) begin
                fail_timeout("the DUT to become idle");
            end else if (!key_panel_top_inst.empty || key_panel_top_inst.evt_strobe ||
                         value !== value_d || status !== status_d) begin
                quiet_cnt <= 0;
            end else if (quiet_cnt >= QUIET_CYCLES) begin
                check_equal("value", 32'(value), 32'(model.value));
                check_equal("step_large", 32'(status.step_large), 32'(model.step_large));
                check_equal("overflow", 32'(status.overflow), 32'd0);
                check_equal("release_count", 32'(status.release_count), 32'(model.releases));
                check_done <= 1'b1;
            end else begin
                quiet_cnt <= quiet_cnt + 1;
            end
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    // Inputs change 10 ns after the rising edge
    task automatic next_cycle();
        @(posedge CLK);
        #10;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic run_check();
        int t;
        t         = 0;
        check_req = 1'b1;
        while (!check_done && t < CHECK_TIMEOUT + 100) begin
            @(posedge CLK);
            t++;
        end
        if (!check_done) begin
            fail_timeout("the check process");
        end else begin
            #10;
            check_req = 1'b0;
            next_cycle();
        end
    endtask

    // Long press of every key in mask, all released together
    task automatic tap_keys(input logic [NK-1:0] mask, input int hold, input int rest);
        keys = keys | mask;
        idle_cycles(hold);
        keys = keys & ~mask;
        idle_cycles(rest);
        for (int k = 0; k < NK; k++) begin
            if (mask[k]) begin
                model = apply_event(model, k, 1'b1);
            end
        end
        for (int k = 0; k < NK; k++) begin
            if (mask[k]) begin
                model = apply_event(model, k, 1'b0);
            end
        end
        run_check();
    endtask

    task automatic glitch_key(input int k, input int len);
        keys[k] = 1'b1;
        idle_cycles(len);
        keys[k] = 1'b0;
        run_check();
    endtask

    // Contact bounce that dies out low inside one settle window
    task automatic bounce_key(input int k);
        int highs [3];
        int lows [3];
        highs = '{3, 4, 2};
        lows  = '{2, 3, 1};
        for (int i = 0; i < 3; i++) begin
            keys[k] = 1'b1;
            idle_cycles(highs[i]);
            keys[k] = 1'b0;
            idle_cycles(lows[i]);
        end
        run_check();
    endtask

    initial begin
        int            t;
        int            hold;
        int            rest;
        logic [NK-1:0] mask;
        keys      = '0;
        check_req = 1'b0;
        model     = '0;
        lcg_state = 32'd31202;
        t         = 0;
        while (RST_N !== 1'b1 && t < RESET_TIMEOUT) begin
            @(posedge CLK);
            t++;
        end
        if (RST_N !== 1'b1) begin
            fail_timeout("reset release");
        end else begin
            next_cycle();
            run_check();

            // Small steps, wrap below zero, then large steps
            tap_keys(4'b0001, 40, 40);
            tap_keys(4'b0010, 40, 40);
            tap_keys(4'b0010, 30, 35);
            tap_keys(4'b0001, 45, 30);
            tap_keys(4'b1000, 35, 40);
            tap_keys(4'b0001, 30, 30);
            tap_keys(4'b0010, 30, 30);
            tap_keys(4'b0010, 50, 30);
            tap_keys(4'b1000, 30, 30);
            tap_keys(4'b0001, 30, 30);
            tap_keys(4'b0100, 40, 40);

            // Short pulses never reach the controller
            glitch_key(0, 1);
            glitch_key(1, 5);
            glitch_key(2, 12);
            glitch_key(3, 19);
            bounce_key(0);
            bounce_key(2);

            // Several keys in the same cycle
            tap_keys(4'b0011, 40, 40);
            tap_keys(4'b1001, 40, 40);
            tap_keys(4'b1111, 35, 45);
            tap_keys(4'b0101, 30, 30);
            tap_keys(4'b1100, 30, 30);

            for (int s = 0; s < RANDOM_STEPS; s++) begin
                lcg_state = lcg_next(lcg_state);
                mask      = lcg_state[19:16];
                if (mask == '0) begin
                    mask = 4'b0001 << lcg_state[21:20];
                end
                lcg_state = lcg_next(lcg_state);
                hold      = 30 + int'(lcg_state[21:16]);
                lcg_state = lcg_next(lcg_state);
                rest      = 30 + int'(lcg_state[20:16]);
                tap_keys(mask, hold, rest);
            end

            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
    output logic CLK,
    output logic RST_N
);

    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 10;

    // 100 ns clock
    initial begin
        CLK = 1'b0;
        forever begin
            #HALF_PERIOD;
            CLK = ~CLK;
        end
    end

    // Release away from the clock edge
    initial begin
        RST_N = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        #10;
        RST_N = 1'b1;
    end

endmodule
